// ==== Makefile ====
# Verilator build and run of the histogram testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module histTb -f sim.f -Mdir obj_dir -o histTb

# pass only when the log holds the pass line
run: compile
	./obj_dir/histTb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/binRam.sv ====
`timescale 1ns/1ps

module binRam (
    input  logic                        clk,
    input  logic                        rdEn,
    input  logic [histPkg::ADDR_W-1:0]  rdAddr,
    input  logic                        wrEn,
    input  logic [histPkg::ADDR_W-1:0]  wrAddr,
    input  logic [histPkg::COUNT_W-1:0] wrData,
    output logic [histPkg::COUNT_W-1:0] rdData
);
    import histPkg::*;

    // one word per bin of every pixel
    logic [COUNT_W-1:0] mem [PIXEL_NUM * BIN_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // same-address read and write returns the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== logic/histBuilder.sv ====
`timescale 1ns/1ps

module histBuilder (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        bufValid,
    input  logic [histPkg::PIXEL_W-1:0] bufPixel,
    input  logic [histPkg::BIN_W-1:0]   bufBin,
    input  logic                        scanBusy,
    input  logic                        scanRdEn,
    input  logic [histPkg::ADDR_W-1:0]  scanRdAddr,
    input  logic                        scanWrEn,
    input  logic [histPkg::ADDR_W-1:0]  scanWrAddr,
    input  logic [histPkg::COUNT_W-1:0] rdData,
    output logic                        bufPop,
    output logic                        frameDone,
    output logic                        rdEn,
    output logic [histPkg::ADDR_W-1:0]  rdAddr,
    output logic                        wrEn,
    output logic [histPkg::ADDR_W-1:0]  wrAddr,
    output logic [histPkg::COUNT_W-1:0] wrData,
    output logic [histPkg::COUNT_W-1:0] scanData
);
    import histPkg::*;

    // IDLE waits for the scanner, BUILD takes stamps, DRAIN writes the last one
    typedef enum logic [1:0] {
        IDLE,
        BUILD,
        DRAIN
    } stateT;

    localparam logic [EVENT_CNT_W-1:0] LAST_EVENT = EVENT_CNT_W'(FRAME_EVENTS - 1);

    stateT state;
    stateT nextState;

    logic [EVENT_CNT_W-1:0] eventCnt;
    logic                   lastPop;

    // read stage, address of the stamp whose count is on rdData
    logic               s1Valid;
    logic [ADDR_W-1:0]  s1Addr;

    // previous write, for the back-to-back hazard
    logic               fwdValid;
    logic [ADDR_W-1:0]  fwdAddr;
    logic [COUNT_W-1:0] fwdData;

    logic [COUNT_W-1:0] baseCount;
    logic [COUNT_W-1:0] incCount;

    // pop only while building and the scanner is off the memory
    assign bufPop  = (state == BUILD) && bufValid && !scanBusy;
    assign lastPop = bufPop && (eventCnt == LAST_EVENT);

    always_comb begin
        nextState = state;
        case (state)
            // frameDone still high means the scan has not raised scanBusy yet
            IDLE:    if (!scanBusy && !frameDone) nextState = BUILD;
            BUILD:   if (lastPop) nextState = DRAIN;
            DRAIN:   nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            eventCnt  <= '0;
            s1Valid   <= 1'b0;
            fwdValid  <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            state <= nextState;
            if (lastPop) begin
                eventCnt <= '0;
            end else if (bufPop) begin
                eventCnt <= eventCnt + 1'b1;
            end
            s1Valid  <= bufPop;
            fwdValid <= s1Valid;
            // final write lands at the edge that leaves DRAIN
            frameDone <= (state == DRAIN);
        end
    end

    // payload of the pipeline
    always_ff @(posedge clk) begin
        s1Addr  <= {bufPixel, bufBin};
        fwdAddr <= s1Addr;
        fwdData <= incCount;
    end

    // memory still holds the stale word when the last write hit this bin
    assign baseCount = (fwdValid && (fwdAddr == s1Addr)) ? fwdData : rdData;
    // saturating increment
    assign incCount  = (baseCount == {COUNT_W{1'b1}}) ? baseCount : baseCount + 1'b1;

    // memory ports, lent to the scanner while it runs
    assign rdEn   = scanBusy ? scanRdEn : bufPop;
    assign rdAddr = scanBusy ? scanRdAddr : {bufPixel, bufBin};
    assign wrEn   = scanBusy ? scanWrEn : s1Valid;
    assign wrAddr = scanBusy ? scanWrAddr : s1Addr;
    // scanner writes zeros back
    assign wrData = scanBusy ? '0 : incCount;

    assign scanData = rdData;

endmodule

// ==== logic/histPkg.sv ====
package histPkg;

    // pixel and bin geometry
    localparam int unsigned PIXEL_NUM = 4;
    localparam int unsigned BIN_NUM = 16;

    // index widths
    localparam int unsigned PIXEL_W = $clog2(PIXEL_NUM);
    localparam int unsigned BIN_W = $clog2(BIN_NUM);

    // bin memory address, pixel above bin
    localparam int unsigned ADDR_W = PIXEL_W + BIN_W;

    // per-bin count, saturates at all ones
    localparam int unsigned COUNT_W = 8;

    // stamps per frame
    // large enough that one bin can saturate
    localparam int unsigned FRAME_EVENTS = 320;
    localparam int unsigned EVENT_CNT_W = $clog2(FRAME_EVENTS);

    // stamp buffer depth, also the sender's initial credit count
    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

// ==== logic/histTop.sv ====
`timescale 1ns/1ps

module histTop (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        stampValid,
    input  logic [histPkg::PIXEL_W-1:0] stampPixel,
    input  logic [histPkg::BIN_W-1:0]   stampBin,
    output logic                        creditReturn,
    output logic                        peakValid,
    output logic [histPkg::PIXEL_W-1:0] peakPixel,
    output logic [histPkg::BIN_W-1:0]   peakBin,
    output logic [histPkg::COUNT_W-1:0] peakCount
);
    import histPkg::*;

    // buffer head
    logic               bufValid;
    logic [PIXEL_W-1:0] bufPixel;
    logic [BIN_W-1:0]   bufBin;
    logic               bufPop;

    // memory ports
    logic               rdEn;
    logic [ADDR_W-1:0]  rdAddr;
    logic [COUNT_W-1:0] rdData;
    logic               wrEn;
    logic [ADDR_W-1:0]  wrAddr;
    logic [COUNT_W-1:0] wrData;

    // scanner side, routed through the builder
    logic               frameDone;
    logic               scanBusy;
    logic               scanRdEn;
    logic [ADDR_W-1:0]  scanRdAddr;
    logic               scanWrEn;
    logic [ADDR_W-1:0]  scanWrAddr;
    logic [COUNT_W-1:0] scanData;

    stampBuffer stampBuffer_inst (
        .clk(clk), .res(res),
        .stampValid(stampValid), .stampPixel(stampPixel), .stampBin(stampBin),
        .bufPop(bufPop),
        .bufValid(bufValid), .bufPixel(bufPixel), .bufBin(bufBin),
        .creditReturn(creditReturn)
    );

    histBuilder histBuilder_inst (
        .clk(clk), .res(res),
        .bufValid(bufValid), .bufPixel(bufPixel), .bufBin(bufBin),
        .scanBusy(scanBusy), .scanRdEn(scanRdEn), .scanRdAddr(scanRdAddr),
        .scanWrEn(scanWrEn), .scanWrAddr(scanWrAddr), .rdData(rdData),
        .bufPop(bufPop), .frameDone(frameDone),
        .rdEn(rdEn), .rdAddr(rdAddr), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .scanData(scanData)
    );

    binRam binRam_inst (
        .clk(clk),
        .rdEn(rdEn), .rdAddr(rdAddr),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdData(rdData)
    );

    peakScanner peakScanner_inst (
        .clk(clk), .res(res),
        .frameDone(frameDone), .scanData(scanData),
        .scanBusy(scanBusy), .scanRdEn(scanRdEn), .scanRdAddr(scanRdAddr),
        .scanWrEn(scanWrEn), .scanWrAddr(scanWrAddr),
        .peakValid(peakValid), .peakPixel(peakPixel), .peakBin(peakBin),
        .peakCount(peakCount)
    );

endmodule

// ==== logic/peakScanner.sv ====
`timescale 1ns/1ps

module peakScanner (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        frameDone,
    input  logic [histPkg::COUNT_W-1:0] scanData,
    output logic                        scanBusy,
    output logic                        scanRdEn,
    output logic [histPkg::ADDR_W-1:0]  scanRdAddr,
    output logic                        scanWrEn,
    output logic [histPkg::ADDR_W-1:0]  scanWrAddr,
    output logic                        peakValid,
    output logic [histPkg::PIXEL_W-1:0] peakPixel,
    output logic [histPkg::BIN_W-1:0]   peakBin,
    output logic [histPkg::COUNT_W-1:0] peakCount
);
    import histPkg::*;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(PIXEL_NUM * BIN_NUM - 1);
    localparam logic [BIN_W-1:0]  LAST_BIN  = BIN_W'(BIN_NUM - 1);

    // pass requested out of reset
    logic launch;
    // set for the clear pass after reset, no results then
    logic clearPass;

    // address whose word is on scanData this cycle
    logic              s1Valid;
    logic [ADDR_W-1:0] s1Addr;

    logic [PIXEL_W-1:0] curPixel;
    logic [BIN_W-1:0]   curBin;
    logic               better;

    // running peak of the current pixel
    logic [COUNT_W-1:0] maxCount;
    logic [BIN_W-1:0]   maxBin;

    assign curPixel = s1Addr[ADDR_W-1 -: PIXEL_W];
    assign curBin   = s1Addr[BIN_W-1:0];
    // strictly greater, lower bin keeps a tie
    assign better   = (curBin == '0) || (scanData > maxCount);

    // zero write one cycle behind the read of the same word
    assign scanWrEn   = s1Valid;
    assign scanWrAddr = s1Addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            launch     <= 1'b1;
            clearPass  <= 1'b1;
            scanBusy   <= 1'b1;
            scanRdEn   <= 1'b0;
            scanRdAddr <= '0;
            s1Valid    <= 1'b0;
            peakValid  <= 1'b0;
        end else begin
            launch <= 1'b0;
            // read walk over every address
            if (launch || frameDone) begin
                scanRdEn   <= 1'b1;
                scanRdAddr <= '0;
                scanBusy   <= 1'b1;
            end else if (scanRdEn) begin
                scanRdAddr <= scanRdAddr + 1'b1;
                if (scanRdAddr == LAST_ADDR) begin
                    scanRdEn <= 1'b0;
                end
            end
            // a frame pass reports peaks
            if (frameDone) begin
                clearPass <= 1'b0;
            end
            s1Valid <= scanRdEn;
            // hand the memory back after the last zero write
            if (s1Valid && (s1Addr == LAST_ADDR)) begin
                scanBusy <= 1'b0;
            end
            peakValid <= s1Valid && (curBin == LAST_BIN) && !clearPass;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= scanRdAddr;
        // first bin restarts the maximum
        if (s1Valid && better) begin
            maxCount <= scanData;
            maxBin   <= curBin;
        end
        // result includes the last bin itself
        if (s1Valid && (curBin == LAST_BIN)) begin
            peakPixel <= curPixel;
            peakBin   <= better ? curBin : maxBin;
            peakCount <= better ? scanData : maxCount;
        end
    end

endmodule

// ==== logic/stampBuffer.sv ====
`timescale 1ns/1ps

module stampBuffer (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        stampValid,
    input  logic [histPkg::PIXEL_W-1:0] stampPixel,
    input  logic [histPkg::BIN_W-1:0]   stampBin,
    input  logic                        bufPop,
    output logic                        bufValid,
    output logic [histPkg::PIXEL_W-1:0] bufPixel,
    output logic [histPkg::BIN_W-1:0]   bufBin,
    output logic                        creditReturn
);
    import histPkg::*;

    // storage for the stamp fields
    logic [PIXEL_W-1:0] pixMem [FIFO_DEPTH];
    logic [BIN_W-1:0]   binMem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    // occupancy, one bit wider than the pointers
    logic [FIFO_PTR_W:0]   fill;

    // the sender only sends on a credit, so a push never meets a full buffer
    always_ff @(posedge clk) begin
        if (stampValid) begin
            pixMem[wrPtr] <= stampPixel;
            binMem[wrPtr] <= stampBin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            fill         <= '0;
            creditReturn <= 1'b0;
        end else begin
            // depth is a power of two, pointers wrap on their own
            if (stampValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (bufPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({stampValid, bufPop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // one credit back per popped stamp, a cycle later
            creditReturn <= bufPop;
        end
    end

    // head entry
    assign bufValid = (fill != '0);
    assign bufPixel = pixMem[rdPtr];
    assign bufBin   = binMem[rdPtr];

endmodule

// ==== sim.f ====
+incdir+verif
logic/histPkg.sv
logic/stampBuffer.sv
logic/binRam.sv
logic/histBuilder.sv
logic/peakScanner.sv
logic/histTop.sv
verif/histTb.sv

// ==== verif/histModel.svh ====
`ifndef HIST_MODEL_SVH
`define HIST_MODEL_SVH

// frames in the run and their stimulus kinds
localparam int FRAME_TOTAL   = 5;
localparam int MODE_RANDOM   = 0;
localparam int MODE_HAZARD   = 1;
localparam int MODE_SATURATE = 2;
localparam int MODE_TIE      = 3;

localparam logic [31:0] LFSR_SEED = 32'h78ca_4125;
// watchdog budget in clock periods
localparam int TIMEOUT_CYCLES = FRAME_TOTAL * (FRAME_EVENTS * 4 + 200);
localparam int COUNT_MAX      = (1 << COUNT_W) - 1;
// stamps per pixel in the structured frames
localparam int PER_PIXEL      = FRAME_EVENTS / PIXEL_NUM;

logic [31:0] lfsrState = LFSR_SEED;
// stamps of the frame being sent, per address, not saturated
int refHist [PIXEL_NUM * BIN_NUM];

function automatic int modeOf(input int frame);
    case (frame)
        1:       return MODE_HAZARD;
        2:       return MODE_SATURATE;
        3:       return MODE_TIE;
        default: return MODE_RANDOM;
    endcase
endfunction

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one step per bit taken
function automatic int unsigned randBits(input int n);
    int unsigned r;
    int k;
    r = 0;
    for (k = 0; k < n; k++) begin
        lfsrState = lfsrNext(lfsrState);
        r = (r << 1) | {31'b0, lfsrState[0]};
    end
    return r;
endfunction

function automatic int satCount(input int n);
    return (n > COUNT_MAX) ? COUNT_MAX : n;
endfunction

// largest saturated count of a pixel, then the lowest bin holding it
function automatic void refPeak(input int pixel, output logic [BIN_W-1:0] bin,
                                output logic [COUNT_W-1:0] count);
    int best;
    int b;
    best = 0;
    for (b = 0; b < BIN_NUM; b++) begin
        if (satCount(refHist[pixel * BIN_NUM + b]) > best) begin
            best = satCount(refHist[pixel * BIN_NUM + b]);
        end
    end
    bin = '0;
    // walk down so the lowest match is left last
    for (b = BIN_NUM - 1; b >= 0; b--) begin
        if (satCount(refHist[pixel * BIN_NUM + b]) == best) begin
            bin = BIN_W'(b);
        end
    end
    count = COUNT_W'(best);
endfunction

`endif

// ==== verif/histTb.sv ====
`timescale 1ns/1ps

module histTb;
    import histPkg::*;

    `include "histModel.svh"

    // input drive offset after the rising edge
    localparam int DRIVE_DELAY = 2;

    logic               clk = 1'b0;
    logic               res;
    logic               stampValid;
    logic [PIXEL_W-1:0] stampPixel;
    logic [BIN_W-1:0]   stampBin;
    logic               creditReturn;
    logic               peakValid;
    logic [PIXEL_W-1:0] peakPixel;
    logic [BIN_W-1:0]   peakBin;
    logic [COUNT_W-1:0] peakCount;

    // credit bookkeeping of the sender
    int sentCount = 0;
    int creditsBack = 0;
    int framesChecked = 0;

    // expected results per pixel with frames in order
    logic [PIXEL_W-1:0] expPixel [$];
    logic [BIN_W-1:0]   expBin [$];
    logic [COUNT_W-1:0] expCount [$];

    histTop histTop_inst (
        .clk(clk), .res(res),
        .stampValid(stampValid), .stampPixel(stampPixel), .stampBin(stampBin),
        .creditReturn(creditReturn),
        .peakValid(peakValid), .peakPixel(peakPixel), .peakBin(peakBin),
        .peakCount(peakCount)
    );

    always #10 clk = ~clk;

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // valid drops at the next drive point unless a send raises it again
    task automatic nextDriveSlot();
        @(posedge clk);
        #DRIVE_DELAY;
        stampValid = 1'b0;
    endtask

    task automatic sendStamp(input logic [PIXEL_W-1:0] p, input logic [BIN_W-1:0] b,
                             input int gap);
        int n;
        for (n = 0; n < gap; n++) begin
            nextDriveSlot();
        end
        // hold off until a credit is back
        while (sentCount - creditsBack >= FIFO_DEPTH) begin
            nextDriveSlot();
        end
        stampValid = 1'b1;
        stampPixel = p;
        stampBin   = b;
        sentCount  = sentCount + 1;
        refHist[int'(p) * BIN_NUM + int'(b)] += 1;
        nextDriveSlot();
    endtask

    task automatic sendFrame(input int mode);
        int i;
        int j;
        int pix;
        int gap;
        logic [PIXEL_W-1:0] p;
        logic [BIN_W-1:0]   b;
        logic [BIN_W-1:0]   pkBin;
        logic [COUNT_W-1:0] pkCount;
        for (i = 0; i < FRAME_EVENTS; i++) begin
            gap = 0;
            pix = i / PER_PIXEL;
            j   = i % PER_PIXEL;
            case (mode)
                // long back-to-back runs on one bin
                MODE_HAZARD: begin
                    p = PIXEL_W'(pix);
                    b = (j < 40) ? BIN_W'(3 * pix + 1) : BIN_W'(randBits(BIN_W));
                end
                // whole frame on a single bin
                MODE_SATURATE: begin
                    p = PIXEL_W'(2);
                    b = BIN_W'(9);
                end
                // two bins reach 30 each and bin 0 only 20
                MODE_TIE: begin
                    p = PIXEL_W'(pix);
                    if (j < 60) begin
                        b = ((j % 2) == 0) ? BIN_W'(pix + 9) : BIN_W'(pix + 2);
                    end else begin
                        b = '0;
                    end
                end
                default: begin
                    p = PIXEL_W'(randBits(PIXEL_W));
                    b = BIN_W'(randBits(BIN_W));
                    gap = (randBits(2) == 0) ? int'(randBits(2)) : 0;
                end
            endcase
            sendStamp(p, b, gap);
        end
        // expected peaks of this frame and a clean slate for the next
        for (pix = 0; pix < PIXEL_NUM; pix++) begin
            refPeak(pix, pkBin, pkCount);
            expPixel.push_back(PIXEL_W'(pix));
            expBin.push_back(pkBin);
            expCount.push_back(pkCount);
        end
        for (i = 0; i < PIXEL_NUM * BIN_NUM; i++) begin
            refHist[i] = 0;
        end
    endtask

    // credits coming back
    always @(posedge clk) begin
        if (creditReturn) begin
            assert (creditsBack < sentCount)
                else failRun("credit returned with no stamp outstanding");
            creditsBack <= creditsBack + 1;
        end
    end

    // compare every peak result with the reference
    always @(posedge clk) begin
        if (peakValid) begin
            assert (expPixel.size() != 0)
                else failRun("peak result arrived with no frame pending");
            assert (peakPixel == expPixel[0])
                else failRun($sformatf("FAILED peakPixel got 0x%h expected 0x%h",
                                       peakPixel, expPixel[0]));
            assert (peakBin == expBin[0])
                else failRun($sformatf("FAILED peakBin got 0x%h expected 0x%h",
                                       peakBin, expBin[0]));
            assert (peakCount == expCount[0])
                else failRun($sformatf("FAILED peakCount got 0x%h expected 0x%h",
                                       peakCount, expCount[0]));
            void'(expPixel.pop_front());
            void'(expBin.pop_front());
            void'(expCount.pop_front());
            // last pixel closes the frame so all its credits are back by now
            if (peakPixel == PIXEL_W'(PIXEL_NUM - 1)) begin
                framesChecked = framesChecked + 1;
                assert (creditsBack == framesChecked * FRAME_EVENTS)
                    else failRun($sformatf("FAILED creditReturn count got 0x%h expected 0x%h",
                                           creditsBack, framesChecked * FRAME_EVENTS));
            end
        end
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        failRun($sformatf("run hung, not done after %0d clock cycles", TIMEOUT_CYCLES));
    end

    initial begin
        int frame;
        res        = 1'b0;
        stampValid = 1'b0;
        stampPixel = '0;
        stampBin   = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        res = 1'b1;
        for (frame = 0; frame < FRAME_TOTAL; frame++) begin
            sendFrame(modeOf(frame));
        end
        wait (framesChecked == FRAME_TOTAL);
        $display("TB PASSED");
        $finish;
    end

endmodule
